//--- logic/aluPkg.sv
`default_nettype none

package aluPkg;

	localparam int defaultWidth = 16;

	// Codes 12 to 15 act as opPassA.
	typedef enum logic [3:0] {
		opAdd   = 4'd0,
		opAdc   = 4'd1,
		opSub   = 4'd2,
		opSbc   = 4'd3,
		opAnd   = 4'd4,
		opOr    = 4'd5,
		opXor   = 4'd6,
		opNotA  = 4'd7,
		opShl   = 4'd8,
		opShr   = 4'd9,
		opPassA = 4'd10,
		opPassB = 4'd11
	} aluOp;

	typedef enum logic [2:0] {
		srcReg     = 3'd0,
		srcArg     = 3'd1,
		srcArgLong = 3'd2, // Side A reads B5 as 0.
		srcZero    = 3'd3,
		srcOne     = 3'd4,
		srcAllOnes = 3'd5
	} srcSel;

	typedef enum logic [1:0] {
		ccRun       = 2'd0,
		ccCarryOnly = 2'd1,
		ccHold      = 2'd2
	} ccMode;

	typedef enum logic [1:0] {
		carryAlu  = 2'd0,
		carryZero = 2'd1,
		carryOne  = 2'd2
	} carrySrc;

endpackage

`default_nettype wire

//--- logic/ccIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ccIf;

	logic zero;
	logic carry;
	logic sign;
	logic parity; // Overflow for arithmetic ops.

	modport source (output zero, output carry, output sign, output parity);

	modport sink (input zero, input carry, input sign, input parity);

endinterface

`default_nettype wire

//--- logic/operandSelect.sv
`timescale 1ns/1ns
`default_nettype none

module operandSelect #(
	parameter int dataWidth = 16
) (
	input  wire logic [dataWidth-1:0] regA,
	input  wire logic [dataWidth-1:0] regB,
	input  wire logic [3:0]           argA,
	input  wire logic [3:0]           argB,
	input  wire logic                 b5,
	input  wire aluPkg::srcSel        aSrc,
	input  wire aluPkg::srcSel        bSrc,
	output logic [dataWidth-1:0]      aData,
	output logic [dataWidth-1:0]      bData
);

	function automatic logic [dataWidth-1:0] pickOperand(
		input aluPkg::srcSel        sel,
		input logic [dataWidth-1:0] regWord,
		input logic [3:0]           arg,
		input logic                 ext
	);
		logic [dataWidth-1:0] word;
		case (sel)
			aluPkg::srcReg:
				word = regWord;
			aluPkg::srcArg:
				word = {{(dataWidth-4){1'b0}}, arg};
			aluPkg::srcArgLong:
				word = {{(dataWidth-5){1'b0}}, ext, arg}; // 5-bit field.
			aluPkg::srcZero:
				word = '0;
			aluPkg::srcOne:
				word = {{(dataWidth-1){1'b0}}, 1'b1};
			aluPkg::srcAllOnes:
				word = '1;
			default:
				word = '0;
		endcase
		return word;
	endfunction

	always_comb begin
		aData = pickOperand(aSrc, regA, argA, 1'b0); // No B5 on side A.
		bData = pickOperand(bSrc, regB, argB, b5);
	end

endmodule

`default_nettype wire

//--- logic/aluCore.sv
`timescale 1ns/1ns
`default_nettype none

module aluCore #(
	parameter int dataWidth = 16
) (
	input  wire logic [dataWidth-1:0] aData,
	input  wire logic [dataWidth-1:0] bData,
	input  wire aluPkg::aluOp         op,
	input  wire logic                 carryIn,
	output logic [dataWidth-1:0]      result,
	ccIf.source                       flags
);

	localparam int msb = dataWidth - 1;

	logic                 useCarry;
	logic [dataWidth:0]   cinWord;
	logic [dataWidth:0]   sum;
	logic [dataWidth:0]   diff;
	logic                 carryOut;
	logic                 overflow;
	logic                 isArith;

	// Only the carry-chained ops see the latched carry.
	assign useCarry = (op == aluPkg::opAdc) || (op == aluPkg::opSbc);
	assign cinWord  = {{dataWidth{1'b0}}, useCarry & carryIn};

	assign sum  = {1'b0, aData} + {1'b0, bData} + cinWord;
	assign diff = {1'b0, aData} - {1'b0, bData} - cinWord; // Top bit is the borrow.

	always_comb begin
		result   = aData;
		carryOut = 1'b0;
		overflow = 1'b0;
		isArith  = 1'b0;
		case (op)
			aluPkg::opAdd,
			aluPkg::opAdc: begin
				result   = sum[msb:0];
				carryOut = sum[dataWidth];
				isArith  = 1'b1;
				overflow = (aData[msb] == bData[msb]) && (sum[msb] != aData[msb]);
			end
			aluPkg::opSub,
			aluPkg::opSbc: begin
				result   = diff[msb:0];
				carryOut = diff[dataWidth];
				isArith  = 1'b1;
				overflow = (aData[msb] != bData[msb]) && (diff[msb] != aData[msb]);
			end
			aluPkg::opAnd: begin
				result = aData & bData;
			end
			aluPkg::opOr: begin
				result = aData | bData;
			end
			aluPkg::opXor: begin
				result = aData ^ bData;
			end
			aluPkg::opNotA: begin
				result = ~aData;
			end
			aluPkg::opShl: begin
				result   = {aData[msb-1:0], 1'b0};
				carryOut = aData[msb]; // Bit shifted out.
			end
			aluPkg::opShr: begin
				result   = {1'b0, aData[msb:1]};
				carryOut = aData[0];
			end
			aluPkg::opPassB: begin
				result = bData;
			end
			default: begin
				result = aData; // opPassA and spare codes.
			end
		endcase
	end

	// Flags for whatever op is on the bus this cycle.
	always_comb begin
		flags.zero   = (result == '0);
		flags.carry  = carryOut;
		flags.sign   = result[msb];
		flags.parity = isArith ? overflow : ~^result; // Even parity otherwise.
	end

endmodule

`default_nettype wire

//--- logic/ccLatch.sv
`timescale 1ns/1ns
`default_nettype none

module ccLatch (
	input  wire logic            CLK,
	input  wire logic            arstN,
	input  wire logic            ccLoad,
	input  wire aluPkg::ccMode   mode,
	input  wire aluPkg::carrySrc cSrc,
	ccIf.sink                    flagsIn,
	output logic                 ccZero,
	output logic                 ccCarry,
	output logic                 ccSign,
	output logic                 ccParity
);

	logic forcedCarry;

	always_comb begin
		case (cSrc)
			aluPkg::carryZero: forcedCarry = 1'b0;
			aluPkg::carryOne:  forcedCarry = 1'b1;
			default:           forcedCarry = flagsIn.carry;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ccZero   <= 1'b0;
			ccCarry  <= 1'b0;
			ccSign   <= 1'b0;
			ccParity <= 1'b0;
		end else if (ccLoad) begin
			case (mode)
				aluPkg::ccRun: begin
					ccZero   <= flagsIn.zero;
					ccCarry  <= flagsIn.carry;
					ccSign   <= flagsIn.sign;
					ccParity <= flagsIn.parity;
				end
				aluPkg::ccCarryOnly: begin
					ccCarry <= forcedCarry;
				end
				default: begin
					// ccHold keeps every flag.
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/fullAlu.sv
`timescale 1ns/1ns
`default_nettype none

module fullAlu #(
	parameter int dataWidth = aluPkg::defaultWidth
) (
	input  wire logic                 CLK,
	input  wire logic                 arstN,
	input  wire logic [dataWidth-1:0] regA,
	input  wire logic [dataWidth-1:0] regB,
	input  wire logic [3:0]           argA,
	input  wire logic [3:0]           argB,
	input  wire logic                 b5,
	input  wire aluPkg::srcSel        aSrc,
	input  wire aluPkg::srcSel        bSrc,
	input  wire aluPkg::aluOp         op,
	input  wire logic                 ccLoad,
	input  wire aluPkg::ccMode        ccMode,
	input  wire aluPkg::carrySrc      carrySrc,
	output logic [dataWidth-1:0]      result,
	output logic [dataWidth-1:0]      aData,
	output logic [dataWidth-1:0]      bData,
	output logic                      ccZero,
	output logic                      ccCarry,
	output logic                      ccSign,
	output logic                      ccParity
);

	ccIf aluFlags ();

	operandSelect #(
		.dataWidth (dataWidth)
	) u_operandSelect (
		.regA  (regA),
		.regB  (regB),
		.argA  (argA),
		.argB  (argB),
		.b5    (b5),
		.aSrc  (aSrc),
		.bSrc  (bSrc),
		.aData (aData),
		.bData (bData)
	);

	aluCore #(
		.dataWidth (dataWidth)
	) u_aluCore (
		.aData   (aData),
		.bData   (bData),
		.op      (op),
		.carryIn (ccCarry), // Latched carry feeds ADC and SBC.
		.result  (result),
		.flags   (aluFlags.source)
	);

	ccLatch u_ccLatch (
		.CLK      (CLK),
		.arstN    (arstN),
		.ccLoad   (ccLoad),
		.mode     (ccMode),
		.cSrc     (carrySrc),
		.flagsIn  (aluFlags.sink),
		.ccZero   (ccZero),
		.ccCarry  (ccCarry),
		.ccSign   (ccSign),
		.ccParity (ccParity)
	);

endmodule

`default_nettype wire

//--- dv/fullAluChecks_assert.sv
`timescale 1ns/1ns
`default_nettype none

module fullAluChecks #(
	parameter int dataWidth = 16
) (
	input wire logic                 CLK,
	input wire logic                 arstN,
	input wire logic [dataWidth-1:0] regA,
	input wire logic [dataWidth-1:0] regB,
	input wire logic [3:0]           argA,
	input wire logic [3:0]           argB,
	input wire logic                 b5,
	input wire aluPkg::srcSel        aSrc,
	input wire aluPkg::srcSel        bSrc,
	input wire aluPkg::aluOp         op,
	input wire logic                 ccLoad,
	input wire aluPkg::ccMode        ccMode,
	input wire aluPkg::carrySrc      carrySrc,
	input wire logic [dataWidth-1:0] result,
	input wire logic [dataWidth-1:0] aData,
	input wire logic [dataWidth-1:0] bData,
	input wire logic                 ccZero,
	input wire logic                 ccCarry,
	input wire logic                 ccSign,
	input wire logic                 ccParity,
	input wire logic                 aluZero,
	input wire logic                 aluCarry,
	input wire logic                 aluSign,
	input wire logic                 aluParity
);

	localparam int msb = dataWidth - 1;
	localparam longint maxSigned = (longint'(1) <<< msb) - 1;
	localparam longint minSigned = -(longint'(1) <<< msb);
	localparam longint maxUnsigned = (longint'(1) <<< dataWidth) - 1;

	logic [dataWidth-1:0] expA;
	logic [dataWidth-1:0] expB;
	logic [dataWidth-1:0] expResult;
	longint               wideSum;
	logic                 cinBit;
	logic                 expCarry;
	logic                 expOverflow;
	logic                 isArith;
	logic                 expForced;
	longint               signedResult;
	logic [3:0]           expFlags; // Zero, carry, sign, parity.

	logic resetBad = 1'b0;
	logic operandBad = 1'b0;
	logic resultBad = 1'b0;
	logic feedbackBad = 1'b0;
	logic runLoadBad = 1'b0;
	logic holdBad = 1'b0;
	logic carryOnlyBad = 1'b0;

	function automatic logic [dataWidth-1:0] operandFor(
		input aluPkg::srcSel        sel,
		input logic [dataWidth-1:0] regWord,
		input logic [3:0]           arg,
		input logic                 hi
	);
		case (sel)
			aluPkg::srcReg:     return regWord;
			aluPkg::srcArg:     return dataWidth'(arg);
			aluPkg::srcArgLong: return dataWidth'({hi, arg});
			aluPkg::srcOne:     return dataWidth'(1);
			aluPkg::srcAllOnes: return '1;
			default:            return '0;
		endcase
	endfunction

	always_comb begin
		expA = operandFor(aSrc, regA, argA, 1'b0);
		expB = operandFor(bSrc, regB, argB, b5);
		cinBit = ((op == aluPkg::opAdc) || (op == aluPkg::opSbc)) ? ccCarry : 1'b0;
		wideSum = 0;
		signedResult = 0;
		expCarry = 1'b0;
		isArith = 1'b0;
		expResult = expA;
		case (op)
			aluPkg::opAdd,
			aluPkg::opAdc: begin
				isArith = 1'b1;
				wideSum = longint'(expA) + longint'(expB) + longint'(cinBit);
				expResult = dataWidth'(wideSum);
				expCarry = wideSum > maxUnsigned;
				signedResult = longint'($signed(expA)) + longint'($signed(expB))
					+ longint'(cinBit);
			end
			aluPkg::opSub,
			aluPkg::opSbc: begin
				isArith = 1'b1;
				expResult = expA - expB - dataWidth'(cinBit);
				expCarry = ({1'b0, expB} + {{dataWidth{1'b0}}, cinBit}) > {1'b0, expA};
				signedResult = longint'($signed(expA)) - longint'($signed(expB))
					- longint'(cinBit);
			end
			aluPkg::opAnd:   expResult = expA & expB;
			aluPkg::opOr:    expResult = expA | expB;
			aluPkg::opXor:   expResult = expA ^ expB;
			aluPkg::opNotA:  expResult = ~expA;
			aluPkg::opShl: begin
				expResult = expA << 1;
				expCarry = expA[msb];
			end
			aluPkg::opShr: begin
				expResult = expA >> 1;
				expCarry = expA[0];
			end
			aluPkg::opPassB: expResult = expB;
			default:         expResult = expA;
		endcase
		expOverflow = (signedResult > maxSigned) || (signedResult < minSigned);
		expFlags[3] = (expResult == '0);
		expFlags[2] = expCarry;
		expFlags[1] = expResult[msb];
		expFlags[0] = isArith ? expOverflow : (($countones(expResult) % 2) == 0);
		case (carrySrc)
			aluPkg::carryZero: expForced = 1'b0;
			aluPkg::carryOne:  expForced = 1'b1;
			default:           expForced = expCarry;
		endcase
	end

	resetChk: assert property (@(posedge CLK)
		(!arstN || !$past(arstN)) |-> ({ccZero, ccCarry, ccSign, ccParity} == 4'b0000))
		else begin
			resetBad = 1'b1;
			$error("Flags not clear around reset.");
		end

	operandChk: assert property (@(posedge CLK) (aData == expA) && (bData == expB))
		else begin
			operandBad = 1'b1;
			$error("Operand word mismatch.");
		end

	resultChk: assert property (@(posedge CLK) (result == expResult)
		&& ({aluZero, aluCarry, aluSign, aluParity} == expFlags))
		else begin
			resultBad = 1'b1;
			$error("ALU result or flags mismatch.");
		end

	// ADC and SBC pick up the carry shown on the output.
	feedbackChk: assert property (@(posedge CLK)
		((op == aluPkg::opAdc) || (op == aluPkg::opSbc)) |->
		(result == ((op == aluPkg::opAdc) ? expA + expB + dataWidth'(ccCarry)
			: expA - expB - dataWidth'(ccCarry))))
		else begin
			feedbackBad = 1'b1;
			$error("Carry feedback mismatch.");
		end

	runLoadChk: assert property (@(posedge CLK) disable iff (!arstN)
		($past(arstN) && $past(ccLoad) && ($past(ccMode) == aluPkg::ccRun)) |->
		({ccZero, ccCarry, ccSign, ccParity} == $past(expFlags)))
		else begin
			runLoadBad = 1'b1;
			$error("Flags wrong after a full load.");
		end

	holdChk: assert property (@(posedge CLK) disable iff (!arstN)
		($past(arstN) && (!$past(ccLoad) || ($past(ccMode) == aluPkg::ccHold))) |->
		({ccZero, ccCarry, ccSign, ccParity} == $past({ccZero, ccCarry, ccSign, ccParity})))
		else begin
			holdBad = 1'b1;
			$error("Flags moved without a load.");
		end

	carryOnlyChk: assert property (@(posedge CLK) disable iff (!arstN)
		($past(arstN) && $past(ccLoad) && ($past(ccMode) == aluPkg::ccCarryOnly)) |->
		(({ccZero, ccSign, ccParity} == $past({ccZero, ccSign, ccParity}))
			&& (ccCarry == $past(expForced))))
		else begin
			carryOnlyBad = 1'b1;
			$error("Carry-only update mismatch.");
		end

endmodule

bind fullAlu fullAluChecks #(
	.dataWidth (dataWidth)
) aluChecks (
	.CLK       (CLK),
	.arstN     (arstN),
	.regA      (regA),
	.regB      (regB),
	.argA      (argA),
	.argB      (argB),
	.b5        (b5),
	.aSrc      (aSrc),
	.bSrc      (bSrc),
	.op        (op),
	.ccLoad    (ccLoad),
	.ccMode    (ccMode),
	.carrySrc  (carrySrc),
	.result    (result),
	.aData     (aData),
	.bData     (bData),
	.ccZero    (ccZero),
	.ccCarry   (ccCarry),
	.ccSign    (ccSign),
	.ccParity  (ccParity),
	.aluZero   (aluFlags.zero),
	.aluCarry  (aluFlags.carry),
	.aluSign   (aluFlags.sign),
	.aluParity (aluFlags.parity)
);

`default_nettype wire

//--- dv/fullAluTb.sv
`timescale 1ns/1ns
`default_nettype none

module fullAluTb;

	localparam int dw = aluPkg::defaultWidth;

	logic            CLK;
	logic            arstN;
	logic [dw-1:0]   regA;
	logic [dw-1:0]   regB;
	logic [3:0]      argA;
	logic [3:0]      argB;
	logic            b5;
	aluPkg::srcSel   aSrc;
	aluPkg::srcSel   bSrc;
	aluPkg::aluOp    op;
	logic            ccLoad;
	aluPkg::ccMode   ccMode;
	aluPkg::carrySrc carrySrc;
	logic [dw-1:0]   result;
	logic [dw-1:0]   aData;
	logic [dw-1:0]   bData;
	logic            ccZero;
	logic            ccCarry;
	logic            ccSign;
	logic            ccParity;
	integer          seed;
	logic [31:0]     r;

	fullAlu u_fullAlu (
		.CLK      (CLK),
		.arstN    (arstN),
		.regA     (regA),
		.regB     (regB),
		.argA     (argA),
		.argB     (argB),
		.b5       (b5),
		.aSrc     (aSrc),
		.bSrc     (bSrc),
		.op       (op),
		.ccLoad   (ccLoad),
		.ccMode   (ccMode),
		.carrySrc (carrySrc),
		.result   (result),
		.aData    (aData),
		.bData    (bData),
		.ccZero   (ccZero),
		.ccCarry  (ccCarry),
		.ccSign   (ccSign),
		.ccParity (ccParity)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	function automatic string failedCheckName();
		if (u_fullAlu.aluChecks.resetBad) return "resetChk";
		if (u_fullAlu.aluChecks.operandBad) return "operandChk";
		if (u_fullAlu.aluChecks.resultBad) return "resultChk";
		if (u_fullAlu.aluChecks.feedbackBad) return "feedbackChk";
		if (u_fullAlu.aluChecks.runLoadBad) return "runLoadChk";
		if (u_fullAlu.aluChecks.holdBad) return "holdChk";
		if (u_fullAlu.aluChecks.carryOnlyBad) return "carryOnlyChk";
		return "";
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "Run stopped.");
	endtask

	task automatic checkFailures();
		string name;
		name = failedCheckName();
		if (name != "")
			failRun($sformatf("FAILED at %0t ns: assertion %s did not hold", $time, name));
	endtask

	// Inputs change 1 ns after the edge.
	task automatic stepCycle();
		@(posedge CLK);
		#1;
		checkFailures();
	endtask

	task automatic runOp(input aluPkg::aluOp code, input logic [dw-1:0] a,
		input logic [dw-1:0] b, input logic load, input aluPkg::ccMode mode,
		input aluPkg::carrySrc cs);
		regA = a;
		regB = b;
		aSrc = aluPkg::srcReg;
		bSrc = aluPkg::srcReg;
		op = code;
		ccLoad = load;
		ccMode = mode;
		carrySrc = cs;
		stepCycle();
	endtask

	task automatic waitCarry(input logic value, input int limit);
		int n;
		n = 0;
		while ((ccCarry !== value) && (n < limit)) begin
			stepCycle();
			n++;
		end
		if (ccCarry !== value)
			failRun($sformatf("Timeout: ccCarry did not reach %0b within %0d cycles",
				value, limit));
	endtask

	initial begin
		seed = 32'h3eb9_3540;
		arstN = 1'b0;
		regA = 16'h7fff; // Would set sign and overflow if loaded.
		regB = 16'h0001;
		argA = 4'h0;
		argB = 4'h0;
		b5 = 1'b0;
		aSrc = aluPkg::srcReg;
		bSrc = aluPkg::srcReg;
		op = aluPkg::opAdd;
		ccLoad = 1'b1;
		ccMode = aluPkg::ccRun;
		carrySrc = aluPkg::carryAlu;
		repeat (16) stepCycle();
		arstN = 1'b1;
		ccLoad = 1'b0;
		stepCycle();

		runOp(aluPkg::opAdd, 16'h1234, 16'h4321, 1'b1, aluPkg::ccRun, aluPkg::carryAlu);
		runOp(aluPkg::opAdd, 16'hffff, 16'hffff, 1'b1, aluPkg::ccRun, aluPkg::carryAlu);
		runOp(aluPkg::opPassA, 16'h0000, 16'h0000, 1'b0, aluPkg::ccRun, aluPkg::carryAlu);
		runOp(aluPkg::opSub, 16'h0003, 16'h0005, 1'b1, aluPkg::ccRun, aluPkg::carryAlu);
		runOp(aluPkg::opShl, 16'h8001, 16'h0000, 1'b1, aluPkg::ccRun, aluPkg::carryAlu);
		runOp(aluPkg::opShr, 16'h0001, 16'h0000, 1'b1, aluPkg::ccHold, aluPkg::carryAlu);

		// Forced carry, then ADC and SBC consume it.
		runOp(aluPkg::opAnd, 16'hffff, 16'h0f0f, 1'b1, aluPkg::ccCarryOnly, aluPkg::carryOne);
		waitCarry(1'b1, 4);
		runOp(aluPkg::opAdc, 16'h0001, 16'h0001, 1'b0, aluPkg::ccRun, aluPkg::carryAlu);
		runOp(aluPkg::opSbc, 16'h0005, 16'h0001, 1'b0, aluPkg::ccRun, aluPkg::carryAlu);
		runOp(aluPkg::opShr, 16'h0000, 16'h0000, 1'b1, aluPkg::ccCarryOnly, aluPkg::carryZero);
		waitCarry(1'b0, 4);
		runOp(aluPkg::opShl, 16'h8000, 16'h0000, 1'b1, aluPkg::ccCarryOnly, aluPkg::carryAlu);
		waitCarry(1'b1, 4);
		runOp(aluPkg::opSbc, 16'h0000, 16'h0000, 1'b1, aluPkg::ccRun, aluPkg::carryAlu);

		for (int n = 0; n < 400; n++) begin
			r = $random(seed);
			regA = dw'(r);
			regB = dw'(r >> 16);
			r = $random(seed);
			argA = r[3:0];
			argB = r[7:4];
			b5 = r[8];
			ccLoad = r[9];
			aSrc = aluPkg::srcSel'(3'(r[15:12] % 4'd6));
			bSrc = aluPkg::srcSel'(3'(r[19:16] % 4'd6));
			op = aluPkg::aluOp'(r[23:20]); // Spare codes included.
			ccMode = aluPkg::ccMode'(2'(r[27:24] % 4'd3));
			carrySrc = aluPkg::carrySrc'(2'(r[31:28] % 4'd3));
			stepCycle();
		end

		ccLoad = 1'b0;
		stepCycle();
		if (failedCheckName() != "") begin
			failRun("A check failed at the end of the run");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- all.f
logic/aluPkg.sv
logic/ccIf.sv
logic/operandSelect.sv
logic/aluCore.sv
logic/ccLatch.sv
logic/fullAlu.sv
dv/fullAluChecks_assert.sv
dv/fullAluTb.sv

//--- Makefile
# Verilator build and run of the ALU testbench.

VERILATOR ?= verilator
TOP       ?= fullAluTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
